// ==== rtl/cpu_pkg.sv ====
// cpu package with widths, opcodes, alu operations, control bundle and stage payloads
package cpu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam reg_addr_t halt_reg  = 5'd17;  // ecall argument register
  localparam word_t     halt_code = 32'd10; // exit service number
  localparam word_t     nop_instr = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes in use
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_itype  = 7'b0010011,
    op_store  = 7'b0100011,
    op_rtype  = 7'b0110011,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_eq,  // branch compare, result in bit 0
    alu_ne
  } alu_op_t;

  // decoded control, all zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src;   // operand b from immediate
    logic    branch;
    logic    is_jal;
    logic    is_jalr;
    logic    pc_to_reg; // write link value
    logic    halt;      // marks the halting ecall bubble
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;   // zero unless the instruction writes a register
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd;
    word_t     link;  // pc + 4 for jal / jalr
  } ex_mem_t;

endpackage

// ==== rtl/decode_stage.sv ====
// decode stage with control decode, immediates, register file, halt check and id/ex register
`timescale 1ns/10ps

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::if_id_t    if_id,
  input  logic               stall,
  input  logic               redirect,
  bypass_if.id_sink          bp,
  input  cpu_pkg::reg_addr_t dbg_addr,
  output cpu_pkg::id_ex_t    id_ex,
  output logic               halt_pending,
  output cpu_pkg::word_t     dbg_data
);
  import cpu_pkg::*;

  word_t     rf [2**reg_addr_w];
  word_t     instr;
  opcode_t   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  ctrl_t     ctrl;
  word_t     imm;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     x17_val;
  logic      is_ecall;
  logic      halt_hit;
  id_ex_t    id_next;

  // regfile read with write-through from wb, x0 reads as zero
  function automatic word_t rf_read(input reg_addr_t a);
    if (a == '0) return '0;
    if (bp.wb_reg_write && bp.wb_rd == a) return bp.wb_value;
    return rf[a];
  endfunction

  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b111:  return alu_and;
      3'b110:  return alu_or;
      3'b010:  return alu_slt;
      default: return sub ? alu_sub : alu_add;
    endcase
  endfunction

  assign instr  = if_id.instr;
  assign opcode = opcode_t'(instr[6:0]);
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    ctrl = '0;  // unknown opcodes and ecall decode as bubbles
    case (opcode)
      op_rtype: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_funct3(instr[14:12], instr[30]);
      end
      op_itype: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_from_funct3(instr[14:12], 1'b0); // no subi
      end
      op_load: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_branch: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = instr[12] ? alu_ne : alu_eq; // bne / beq
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.pc_to_reg = 1'b1;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.alu_src   = 1'b1;  // target is rs1 + imm
      end
      default: ;
    endcase
  end

  // immediate per format
  always_comb begin
    case (opcode)
      op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default:   imm = {{20{instr[31]}}, instr[31:20]};  // i-type
    endcase
  end

  // regfile write from wb
  always_ff @(posedge clk) begin
    if (bp.wb_reg_write && bp.wb_rd != '0) rf[bp.wb_rd] <= bp.wb_value;
  end

  always_comb begin
    rs1_val  = rf_read(rs1);
    rs2_val  = rf_read(rs2);
    dbg_data = rf_read(dbg_addr);
    // x17 from mem first, then wb through rf_read
    if (bp.mem_reg_write && bp.mem_rd == halt_reg) x17_val = bp.mem_value;
    else x17_val = rf_read(halt_reg);
  end

  assign is_ecall = (opcode == op_system) && (instr[31:20] == '0);
  assign halt_hit = is_ecall && (x17_val == halt_code);

  always_comb begin
    id_next           = '0;
    id_next.ctrl      = ctrl;
    id_next.ctrl.halt = halt_hit;  // halting ecall rides down as a marked bubble
    id_next.pc        = if_id.pc;
    id_next.rs1_data  = rs1_val;
    id_next.rs2_data  = rs2_val;
    id_next.imm       = imm;
    id_next.rs1       = rs1;
    id_next.rs2       = rs2;
    id_next.rd        = ctrl.reg_write ? rd : '0; // keeps hazard compare exact
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex        <= '0;
      halt_pending <= 1'b0;
    end else begin
      if (stall || redirect || halt_pending) id_ex <= '0; // bubble
      else id_ex <= id_next;
      if (halt_hit && !stall && !redirect) halt_pending <= 1'b1; // sticky
    end
  end

endmodule

// ==== rtl/execute_stage.sv ====
// execute stage with operand forwarding, alu, branch and jump resolution and ex/mem register
`timescale 1ns/10ps

module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::id_ex_t  id_ex,
  bypass_if.ex_sink        bp,
  output cpu_pkg::ex_mem_t ex_mem,
  output logic             redirect,
  output cpu_pkg::word_t   redirect_pc
);
  import cpu_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t rs2_val;  // forwarded, also the store data
  word_t alu_result;
  word_t link;
  logic  taken;

  // newest producer wins, x0 never forwarded
  function automatic word_t forward(input reg_addr_t r, input word_t reg_val);
    if (r != '0 && bp.mem_reg_write && bp.mem_rd == r) return bp.mem_value;
    if (r != '0 && bp.wb_reg_write && bp.wb_rd == r) return bp.wb_value;
    return reg_val;
  endfunction

  always_comb begin
    op_a    = forward(id_ex.rs1, id_ex.rs1_data);
    rs2_val = forward(id_ex.rs2, id_ex.rs2_data);
    op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;
  end

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = word_t'($signed(op_a) < $signed(op_b));
      alu_eq:  alu_result = word_t'(op_a == op_b);
      alu_ne:  alu_result = word_t'(op_a != op_b);
      default: alu_result = op_a + op_b;  // add, address calc
    endcase
  end

  assign taken    = id_ex.ctrl.branch && alu_result[0];
  assign redirect = taken || id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr;
  assign link     = id_ex.pc + 32'd4;

  // jalr clears bit 0 of rs1 + imm
  always_comb begin
    if (id_ex.ctrl.is_jalr) redirect_pc = {alu_result[xlen-1:1], 1'b0};
    else redirect_pc = id_ex.pc + id_ex.imm;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.ctrl <= '0;
    end else begin
      ex_mem <= '{
        ctrl:       id_ex.ctrl,
        alu_result: alu_result,
        store_data: rs2_val,
        rd:         id_ex.rd,
        link:       link
      };
    end
  end

endmodule

// ==== rtl/fetch_stage.sv ====
// fetch stage with pc register, loadable instruction memory and if/id register
`timescale 1ns/10ps

module fetch_stage #(
  parameter int imem_words = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            halt_pending,
  input  logic            redirect,
  input  cpu_pkg::word_t  redirect_pc,
  input  logic            imem_we,
  input  cpu_pkg::word_t  imem_addr,  // byte address, low bits ignored
  input  cpu_pkg::word_t  imem_wdata,
  output cpu_pkg::if_id_t if_id
);
  import cpu_pkg::*;

  localparam int iaddr_w = $clog2(imem_words);

  word_t imem [imem_words];  // word array
  word_t pc;
  word_t instr;

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr[iaddr_w+1:2]] <= imem_wdata;
  end

  assign instr = imem[pc[iaddr_w+1:2]]; // async read

  // static not-taken, fall through unless execute redirects
  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= '0;
      if_id <= '{instr: nop_instr, pc: '0};
    end else if (redirect) begin  // wins over stall
      pc    <= redirect_pc;
      if_id <= '{instr: nop_instr, pc: '0}; // squash wrong path
    end else if (!stall && !halt_pending) begin
      pc    <= pc + 32'd4;
      if_id <= '{instr: instr, pc: pc};
    end
  end

endmodule

// ==== rtl/hazard_unit.sv ====
// hazard unit raising a one cycle stall for load-use and for an ecall right behind an x17 write
`timescale 1ns/10ps

module hazard_unit (
  input  cpu_pkg::word_t     if_id_instr,
  input  cpu_pkg::reg_addr_t ex_rd,       // zero for non-writers and bubbles
  input  logic               ex_mem_read,
  output logic               stall
);
  import cpu_pkg::*;

  opcode_t   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      uses_rs1;
  logic      uses_rs2;
  logic      load_use;
  logic      ecall_wait;

  assign opcode = opcode_t'(if_id_instr[6:0]);
  assign rs1    = if_id_instr[19:15];
  assign rs2    = if_id_instr[24:20];

  assign uses_rs1 = (opcode != op_jal) && (opcode != op_system);
  assign uses_rs2 = (opcode == op_rtype) || (opcode == op_store) || (opcode == op_branch);

  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

  // x17 still in execute, wait one cycle so decode sees it from mem
  assign ecall_wait = (opcode == op_system) && (ex_rd == halt_reg);

  assign stall = load_use || ecall_wait;  // bubble behind it clears ex_rd

endmodule

// ==== rtl/memory_stage.sv ====
// memory stage with data memory, mem/wb register, writeback select and sticky halt flag
`timescale 1ns/10ps

module memory_stage #(
  parameter int dmem_words = 256
) (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::ex_mem_t ex_mem,
  bypass_if.source         bp,
  output logic             halted
);
  import cpu_pkg::*;

  localparam int daddr_w = $clog2(dmem_words);

  word_t              dmem [dmem_words];
  logic [daddr_w-1:0] daddr;
  word_t              rdata;
  word_t              mem_value;
  logic               wb_reg_write;
  reg_addr_t          wb_rd;
  word_t              wb_value;

  assign daddr = ex_mem.alu_result[daddr_w+1:2]; // word index

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.mem_write) dmem[daddr] <= ex_mem.store_data;
  end

  assign rdata = dmem[daddr];  // single cycle read

  // writeback value picked here so mem stage can forward load data
  always_comb begin
    if (ex_mem.ctrl.pc_to_reg) mem_value = ex_mem.link;
    else if (ex_mem.ctrl.mem_to_reg) mem_value = rdata;
    else mem_value = ex_mem.alu_result;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      halted       <= 1'b0;
    end else begin
      wb_reg_write <= ex_mem.ctrl.reg_write;
      if (ex_mem.ctrl.halt) halted <= 1'b1;  // held until reset
    end
    wb_rd    <= ex_mem.rd;
    wb_value <= mem_value;
  end

  assign bp.mem_rd        = ex_mem.rd;
  assign bp.mem_reg_write = ex_mem.ctrl.reg_write;
  assign bp.mem_value     = mem_value;
  assign bp.wb_rd         = wb_rd;
  assign bp.wb_reg_write  = wb_reg_write;
  assign bp.wb_value      = wb_value;

endmodule

// ==== rtl/pipe_cpu.sv ====
// five stage rv32i pipeline top level connecting stages, hazard unit and bypass bus
`timescale 1ns/10ps

module pipe_cpu #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               imem_we,    // program load port
  input  cpu_pkg::word_t     imem_addr,  // byte address
  input  cpu_pkg::word_t     imem_wdata,
  input  cpu_pkg::reg_addr_t dbg_addr,
  output cpu_pkg::word_t     dbg_data,
  output logic               halted
);
  import cpu_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  logic    stall;
  logic    redirect;
  word_t   redirect_pc;
  logic    halt_pending;

  bypass_if bp_i ();

  fetch_stage #(.imem_words(imem_words)) fetch_i (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .halt_pending (halt_pending),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .if_id        (if_id)
  );

  decode_stage decode_i (
    .clk          (clk),
    .reset        (reset),
    .if_id        (if_id),
    .stall        (stall),
    .redirect     (redirect),
    .bp           (bp_i.id_sink),
    .dbg_addr     (dbg_addr),
    .id_ex        (id_ex),
    .halt_pending (halt_pending),
    .dbg_data     (dbg_data)
  );

  execute_stage execute_i (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .bp          (bp_i.ex_sink),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  memory_stage #(.dmem_words(dmem_words)) memory_i (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .bp     (bp_i.source),
    .halted (halted)
  );

  hazard_unit hazard_i (
    .if_id_instr (if_id.instr),
    .ex_rd       (id_ex.rd),
    .ex_mem_read (id_ex.ctrl.mem_read),
    .stall       (stall)
  );

endmodule

// ==== rtl/pipe_if.sv ====
// bypass interface carrying mem and wb stage results to decode and execute
`timescale 1ns/10ps

interface bypass_if;
  import cpu_pkg::*;

  reg_addr_t mem_rd;        // instruction now in mem
  logic      mem_reg_write;
  word_t     mem_value;     // final value incl. load data
  reg_addr_t wb_rd;         // instruction now in wb
  logic      wb_reg_write;
  word_t     wb_value;

  modport source (
    output mem_rd, mem_reg_write, mem_value,
    output wb_rd, wb_reg_write, wb_value
  );

  // operand forwarding
  modport ex_sink (
    input mem_rd, mem_reg_write, mem_value,
    input wb_rd, wb_reg_write, wb_value
  );

  // regfile write port and x17 check
  modport id_sink (
    input mem_rd, mem_reg_write, mem_value,
    input wb_rd, wb_reg_write, wb_value
  );

endinterface

// ==== run.sh ====
#!/usr/bin/env bash
# build the pipeline testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module pipe_cpu_tb -f vlog.f -o pipe_cpu_sim

sim_out=$(./obj_dir/pipe_cpu_sim 2>&1) || true
echo "$sim_out"

# exit status follows the search
grep -q "Regression passed" <<< "$sim_out"

// ==== verification/pipe_cpu_assertions.sv ====
// pipeline assertions on stall length, sticky halt flag and the flush behind a redirect
`timescale 1ns/10ps

module pipe_cpu_assertions (
  input logic            clk,
  input logic            reset,
  input logic            stall,
  input logic            redirect,
  input logic            halted,
  input cpu_pkg::ctrl_t  ex_ctrl  // control of the instruction in execute
);

  // load-use and ecall wait both clear ex_rd behind them
  stall_single: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
    else $error("stall held for two cycles");

  // only reset may clear halted
  halted_sticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
    else $error("halted fell without reset");

  // wrong path in decode becomes a bubble in execute
  redirect_flush: assert property (@(posedge clk) disable iff (reset)
    redirect |=> (ex_ctrl == '0))
    else $error("execute not flushed after a redirect");

endmodule

// ==== verification/pipe_cpu_tb.sv ====
// directed testbench for the rv32i pipeline, loads programs and checks registers after halt
`timescale 1ns/10ps

module pipe_cpu_tb;
  import cpu_pkg::*;

  localparam int    halt_timeout = 500;         // cycles per program
  localparam word_t ecall_w      = 32'h0000_0073;

  logic      clk;
  logic      init_reset;  // from the clock module
  logic      test_reset;  // per test
  logic      reset;
  logic      imem_we;
  word_t     imem_addr;
  word_t     imem_wdata;
  reg_addr_t dbg_addr;
  word_t     dbg_data;
  logic      halted;
  word_t     prog [$];    // program under test

  assign reset = init_reset | test_reset;

  tb_clock clock_i (.clk(clk), .reset(init_reset));

  pipe_cpu #(.imem_words(256), .dmem_words(256)) dut_i (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data),
    .halted     (halted)
  );

  bind pipe_cpu pipe_cpu_assertions assertions_i (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .halted   (halted),
    .ex_ctrl  (id_ex.ctrl)
  );

  // hand assembler with one function per format
  function automatic word_t addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic word_t sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t r_op(input int f3, input int f7, input int rd, input int rs1,
                                 input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  // f3 is 0 for beq and 1 for bne
  function automatic word_t branch(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic word_t jalr(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // debug port read sampled mid cycle
  task automatic check_reg(input int r, input int exp);
    @(negedge clk);
    dbg_addr = r[4:0];
    #1;
    check_value($sformatf("x%0d", r), dbg_data, word_t'(exp));
  endtask

  // load under reset then release and wait for halted
  task automatic run_program(input string name);
    int i;
    int cycles;
    @(negedge clk);
    test_reset = 1'b1;
    for (i = 0; i < prog.size(); i++) begin
      imem_we    = 1'b1;
      imem_addr  = word_t'(i * 4);  // byte address
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (2) @(negedge clk);
    test_reset = 1'b0;
    check_value("halted after reset", {31'b0, halted}, 32'd0);
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout: %s program did not halt within %0d cycles", name, halt_timeout);
      $display("Regression failed");
      $fatal(1, "halt timeout");
    end
  endtask

  task automatic arith_test();
    prog.delete();
    prog.push_back(addi(1, 0, 5));
    prog.push_back(addi(2, 1, 3));         // x1 from mem
    prog.push_back(r_op(0, 0, 3, 2, 1));   // add with operands from mem and wb
    prog.push_back(r_op(0, 32, 4, 3, 2));  // sub
    prog.push_back(r_op(7, 0, 5, 4, 3));   // and
    prog.push_back(r_op(6, 0, 6, 5, 2));   // or
    prog.push_back(r_op(2, 0, 7, 6, 3));   // slt equal
    prog.push_back(r_op(2, 0, 8, 4, 6));   // slt less
    prog.push_back(addi(9, 0, -7));
    prog.push_back(r_op(2, 0, 10, 9, 1));  // signed compare
    prog.push_back(addi(17, 0, 10));
    prog.push_back(ecall_w);
    run_program("arith");
    check_reg(1, 5);
    check_reg(2, 8);
    check_reg(3, 13);
    check_reg(4, 5);
    check_reg(5, 5);   // 0101 & 1101
    check_reg(6, 13);
    check_reg(7, 0);
    check_reg(8, 1);
    check_reg(9, -7);
    check_reg(10, 1);
  endtask

  task automatic load_use_test();
    prog.delete();
    prog.push_back(addi(1, 0, 100));       // base at word 25
    prog.push_back(addi(2, 0, 77));
    prog.push_back(sw(2, 1, 0));           // store data forwarded
    prog.push_back(lw(3, 1, 0));
    prog.push_back(r_op(0, 0, 4, 3, 2));   // load-use on rs1
    prog.push_back(addi(6, 0, -3));
    prog.push_back(sw(6, 1, 4));
    prog.push_back(lw(7, 1, 4));
    prog.push_back(r_op(0, 0, 8, 7, 7));   // both operands from the load
    prog.push_back(addi(17, 0, 10));
    prog.push_back(ecall_w);
    run_program("load_use");
    check_reg(3, 77);
    check_reg(4, 154);
    check_reg(7, -3);
    check_reg(8, -6);
  endtask

  task automatic branch_test();
    prog.delete();
    prog.push_back(addi(1, 0, 4));         // 0
    prog.push_back(addi(2, 0, 4));         // 4
    prog.push_back(addi(3, 0, 1));         // 8 marker
    prog.push_back(addi(6, 0, 2));         // 12 marker
    prog.push_back(branch(0, 1, 2, 12));   // 16 beq taken to 28
    prog.push_back(addi(3, 0, 99));        // 20 squashed
    prog.push_back(addi(6, 0, 98));        // 24 squashed
    prog.push_back(branch(1, 1, 2, 8));    // 28 bne not taken
    prog.push_back(addi(4, 0, 7));         // 32
    prog.push_back(addi(5, 0, 3));         // 36
    prog.push_back(branch(1, 5, 1, 8));    // 40 bne taken to 48
    prog.push_back(addi(6, 0, 55));        // 44 squashed
    prog.push_back(addi(17, 0, 10));       // 48
    prog.push_back(ecall_w);
    run_program("branch");
    check_reg(3, 1);
    check_reg(4, 7);
    check_reg(5, 3);
    check_reg(6, 2);
  endtask

  task automatic jump_test();
    prog.delete();
    prog.push_back(addi(5, 0, 9));         // 0 marker
    prog.push_back(jal(1, 12));            // 4 to 16
    prog.push_back(addi(5, 0, 1));         // 8 skipped
    prog.push_back(addi(5, 0, 2));         // 12 skipped
    prog.push_back(addi(2, 0, 28));        // 16
    prog.push_back(jalr(3, 2, 4));         // 20 to 32 with x2 from mem
    prog.push_back(addi(5, 0, 3));         // 24 skipped
    prog.push_back(addi(5, 0, 4));         // 28 skipped
    prog.push_back(addi(17, 0, 10));       // 32
    prog.push_back(ecall_w);
    run_program("jump");
    check_reg(1, 8);
    check_reg(3, 24);
    check_reg(5, 9);
  endtask

  task automatic halt_test();
    prog.delete();
    prog.push_back(addi(3, 0, 5));         // marker
    prog.push_back(addi(17, 0, 9));
    prog.push_back(ecall_w);               // wrong code so it keeps running
    prog.push_back(addi(2, 0, 21));
    prog.push_back(addi(17, 0, 10));       // right before the ecall
    prog.push_back(ecall_w);               // halts
    prog.push_back(addi(3, 0, 66));        // never retires
    run_program("halt");
    check_reg(2, 21);
    check_reg(3, 5);
    check_reg(17, 10);
  endtask

  // overall guard against a stuck run
  initial begin
    #200000;
    $display("watchdog: simulation ran far past the expected length");
    $display("Regression failed");
    $fatal(1, "watchdog");
  end

  initial begin
    test_reset = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    dbg_addr   = '0;
    arith_test();
    load_use_test();
    branch_test();
    jump_test();
    halt_test();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock source with 10 ns period and a 3 cycle power-on reset
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);  // release away from the sampling edge
    reset = 1'b0;
  end

endmodule

// ==== vlog.f ====
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/pipe_cpu.sv
verification/tb_clock.sv
verification/pipe_cpu_assertions.sv
verification/pipe_cpu_tb.sv
